// ==== design/alu_defines.svh ====
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// sizing for the execute cluster

// issue slots per bundle with one lane each
`define ALU_LANES 4

// datapath width
`define ALU_XLEN 32

// width of the saturating overflow trap counter
`define ALU_TRAP_CNT_W 16

`endif

// ==== design/alu_pkg.sv ====
`default_nettype none

`include "alu_defines.svh"

package alu_pkg;

	typedef logic [`ALU_XLEN-1:0]       word_t;
	typedef logic [31:0]                instr_t;
	typedef logic [4:0]                 reg_idx_t;
	typedef logic [4:0]                 shamt_t;
	typedef logic [3:0]                 alu_op_t;
	typedef logic [`ALU_LANES-1:0]      lane_mask_t;
	typedef logic [`ALU_TRAP_CNT_W-1:0] trap_cnt_t;

	// ALU operation codes
	localparam alu_op_t ALU_ADD  = 4'd0; // traps on overflow
	localparam alu_op_t ALU_SUB  = 4'd1; // traps on overflow
	localparam alu_op_t ALU_OR   = 4'd2;
	localparam alu_op_t ALU_AND  = 4'd3;
	localparam alu_op_t ALU_NOR  = 4'd4;
	localparam alu_op_t ALU_XOR  = 4'd5;
	localparam alu_op_t ALU_SLL  = 4'd6;
	localparam alu_op_t ALU_SRL  = 4'd7;
	localparam alu_op_t ALU_SRA  = 4'd8;
	localparam alu_op_t ALU_SLT  = 4'd9;
	localparam alu_op_t ALU_SLTU = 4'd10;
	localparam alu_op_t ALU_ADDU = 4'd11;
	localparam alu_op_t ALU_SUBU = 4'd12;

	typedef struct packed {
		instr_t instr;
		word_t  rs_val;
		word_t  rt_val;
	} issue_slot_t;

	typedef struct packed {
		logic     valid;
		alu_op_t  op;
		word_t    a;
		word_t    b;
		shamt_t   shamt;
		logic     shamt_sel; // 1 = shamt field, 0 = a[4:0]
		reg_idx_t dest;
		logic     wr_intent; // legal op with nonzero dest
		logic     illegal;
	} lane_op_t;

	typedef struct packed {
		logic     valid;
		word_t    value;
		logic     overflow;
		reg_idx_t dest;
		logic     wr_intent;
		logic     illegal;
	} lane_res_t;

	typedef struct packed {
		logic     we;
		reg_idx_t dest;
		word_t    value;
	} wb_slot_t;

endpackage

`default_nettype wire

// ==== design/alu_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_core import alu_pkg::*; (
	input  wire word_t   a,
	input  wire word_t   b,
	input  wire alu_op_t op,
	input  wire shamt_t  shamt,
	input  wire          shamt_sel,
	output word_t        result,
	output logic         overflow
);

	localparam int MSB = $bits(word_t) - 1;

	shamt_t sh;
	word_t  add_res;
	word_t  sub_res;
	word_t  sll_res;
	word_t  srl_res;
	word_t  sra_res;
	logic   lt_s;
	logic   lt_u;

	assign sh = shamt_sel ? shamt : a[4:0]; // immediate or variable shift

	assign add_res = a + b;
	assign sub_res = a - b;

	// shifts always act on b
	assign sll_res = b << sh;
	assign srl_res = b >> sh;
	assign sra_res = $signed(b) >>> sh; // sign fill

	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	always_comb begin
		case (op)
			ALU_ADD, ALU_ADDU: result = add_res;
			ALU_SUB, ALU_SUBU: result = sub_res;
			ALU_OR:            result = a | b;
			ALU_AND:           result = a & b;
			ALU_NOR:           result = ~(a | b);
			ALU_XOR:           result = a ^ b;
			ALU_SLL:           result = sll_res;
			ALU_SRL:           result = srl_res;
			ALU_SRA:           result = sra_res;
			ALU_SLT:           result = {{MSB{1'b0}}, lt_s};
			ALU_SLTU:          result = {{MSB{1'b0}}, lt_u};
			default:           result = '0; // codes 13..15 unused
		endcase
	end

	// two's-complement overflow applies only to the trapping add and sub
	// an add overflows when the operands agree in sign but the sum does not
	// a sub overflows when the operands differ in sign and the difference follows b
	always_comb begin
		case (op)
			ALU_ADD: overflow = (a[MSB] == b[MSB]) && (add_res[MSB] != a[MSB]);
			ALU_SUB: overflow = (a[MSB] != b[MSB]) && (sub_res[MSB] != a[MSB]);
			default: overflow = 1'b0; // addu/subu never trap
		endcase
	end

endmodule

`default_nettype wire

// ==== design/exec_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_lane import alu_pkg::*; (
	input  wire           clk,
	input  wire           arst_n,
	input  wire lane_op_t op_in,
	output lane_res_t     res
);

	word_t alu_result;
	logic  alu_ovf;

	alu_core u_alu (
		.a         (op_in.a),
		.b         (op_in.b),
		.op        (op_in.op),
		.shamt     (op_in.shamt),
		.shamt_sel (op_in.shamt_sel),
		.result    (alu_result),
		.overflow  (alu_ovf)
	);

	// one register stage per lane
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res <= '0;
		end else begin
			res.valid     <= op_in.valid;
			res.value     <= alu_result;
			res.overflow  <= alu_ovf;
			res.dest      <= op_in.dest;      // carried along for write-back
			res.wr_intent <= op_in.wr_intent;
			res.illegal   <= op_in.illegal;
		end
	end

endmodule

`default_nettype wire

// ==== design/issue_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module issue_decode import alu_pkg::*; (
	input  wire              clk,
	input  wire              arst_n,
	input  wire              in_valid,
	input  wire issue_slot_t slots [`ALU_LANES],
	output lane_op_t         lane_ops [`ALU_LANES]
);

	lane_op_t dec [`ALU_LANES];

	function automatic lane_op_t decode_slot(input issue_slot_t s, input logic v);
		lane_op_t   o;
		logic [5:0] opcode;
		logic [5:0] funct;
		word_t      imm_s;
		word_t      imm_z;

		opcode = s.instr[31:26];
		funct  = s.instr[5:0];
		imm_s  = {{(`ALU_XLEN-16){s.instr[15]}}, s.instr[15:0]};
		imm_z  = {{(`ALU_XLEN-16){1'b0}}, s.instr[15:0]};

		o.valid     = v;
		o.op        = ALU_ADDU; // harmless default that never traps
		o.a         = s.rs_val;
		o.b         = s.rt_val;
		o.shamt     = s.instr[10:6];
		o.shamt_sel = 1'b0;
		o.dest      = s.instr[15:11]; // rd
		o.illegal   = 1'b0;

		if (opcode == 6'h00) begin // R-type takes the op from funct
			case (funct)
				6'h00: o.op = ALU_SLL;
				6'h02: o.op = ALU_SRL;
				6'h03: o.op = ALU_SRA;
				6'h04: o.op = ALU_SLL; // sllv
				6'h06: o.op = ALU_SRL; // srlv
				6'h07: o.op = ALU_SRA; // srav
				6'h20: o.op = ALU_ADD;
				6'h21: o.op = ALU_ADDU;
				6'h22: o.op = ALU_SUB;
				6'h23: o.op = ALU_SUBU;
				6'h24: o.op = ALU_AND;
				6'h25: o.op = ALU_OR;
				6'h26: o.op = ALU_XOR;
				6'h27: o.op = ALU_NOR;
				6'h2a: o.op = ALU_SLT;
				6'h2b: o.op = ALU_SLTU;
				default: o.illegal = 1'b1;
			endcase
			o.shamt_sel = (funct[5:2] == 4'b0000); // sll/srl/sra use shamt field
		end else begin
			o.dest = s.instr[20:16]; // rt
			case (opcode)
				6'h08: o.op = ALU_ADD;  // addi
				6'h09: o.op = ALU_ADDU; // addiu
				6'h0a: o.op = ALU_SLT;  // slti
				6'h0b: o.op = ALU_SLTU; // sltiu
				6'h0c: o.op = ALU_AND;  // andi
				6'h0d: o.op = ALU_OR;   // ori
				6'h0e: o.op = ALU_XOR;  // xori
				6'h0f: o.op = ALU_SLL;  // lui
				default: o.illegal = 1'b1;
			endcase
			// andi/ori/xori/lui zero-extend and the rest sign-extend
			o.b = (opcode[5:2] == 4'b0011) ? imm_z : imm_s;
			if (opcode == 6'h0f) begin
				o.shamt     = 5'd16; // lui = imm << 16
				o.shamt_sel = 1'b1;
			end
		end

		o.wr_intent = !o.illegal && (o.dest != '0);
		return o;
	endfunction

	always_comb begin
		for (int i = 0; i < `ALU_LANES; i++) begin
			dec[i] = decode_slot(slots[i], in_valid);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `ALU_LANES; i++) begin
				lane_ops[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `ALU_LANES; i++) begin
				lane_ops[i] <= dec[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/retire_collect.sv ====
`timescale 1ns/100ps
`default_nettype none

module retire_collect import alu_pkg::*; (
	input  wire            clk,
	input  wire            arst_n,
	input  wire lane_res_t results [$bits(lane_mask_t)],
	output logic           out_valid,
	output wb_slot_t       wb [$bits(lane_mask_t)],
	output lane_mask_t     ovf_mask,
	output lane_mask_t     ill_mask,
	output trap_cnt_t      trap_count
);

	localparam int LANES = $bits(lane_mask_t);
	localparam int CNT_W = $bits(trap_cnt_t);

	lane_mask_t vld;
	lane_mask_t ovf;
	lane_mask_t ill;
	lane_mask_t we_nxt;
	logic [$clog2(LANES+1)-1:0] n_ovf;
	logic [CNT_W:0] cnt_sum; // extra bit catches wrap

	lane_mask_t we_q;
	reg_idx_t   dest_q [LANES];
	word_t      value_q [LANES];

	always_comb begin
		n_ovf = '0;
		for (int i = 0; i < LANES; i++) begin
			vld[i]    = results[i].valid;
			ovf[i]    = results[i].valid && results[i].overflow;
			ill[i]    = results[i].valid && results[i].illegal;
			we_nxt[i] = results[i].valid && results[i].wr_intent && !results[i].overflow;
			n_ovf     = n_ovf + ovf[i];
		end
		cnt_sum = {1'b0, trap_count} + (CNT_W+1)'(n_ovf);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid  <= 1'b0;
			we_q       <= '0;
			ovf_mask   <= '0;
			ill_mask   <= '0;
			trap_count <= '0;
		end else begin
			out_valid  <= |vld; // lanes move in lockstep
			we_q       <= we_nxt;
			ovf_mask   <= ovf;
			ill_mask   <= ill;
			trap_count <= cnt_sum[CNT_W] ? '1 : cnt_sum[CNT_W-1:0]; // saturate
		end
	end

	// payload is only meaningful with out_valid
	always_ff @(posedge clk) begin
		for (int i = 0; i < LANES; i++) begin
			dest_q[i]  <= results[i].dest;
			value_q[i] <= results[i].value;
		end
	end

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			wb[i].we    = we_q[i];
			wb[i].dest  = dest_q[i];
			wb[i].value = value_q[i];
		end
	end

endmodule

`default_nettype wire

// ==== design/alu_cluster.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module alu_cluster import alu_pkg::*; (
	input  wire              clk,
	input  wire              arst_n,
	input  wire              in_valid,
	input  wire issue_slot_t slots [`ALU_LANES],
	output logic             out_valid,
	output wb_slot_t         wb [`ALU_LANES],
	output lane_mask_t       ovf_mask,
	output lane_mask_t       ill_mask,
	output trap_cnt_t        trap_count
);

	lane_op_t  lane_ops [`ALU_LANES]; // decode -> lanes
	lane_res_t lane_res [`ALU_LANES]; // lanes -> retire

	issue_decode u_decode (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.slots    (slots),
		.lane_ops (lane_ops)
	);

	for (genvar g = 0; g < `ALU_LANES; g++) begin : g_lane
		exec_lane u_lane (
			.clk    (clk),
			.arst_n (arst_n),
			.op_in  (lane_ops[g]),
			.res    (lane_res[g])
		);
	end

	retire_collect u_retire (
		.clk        (clk),
		.arst_n     (arst_n),
		.results    (lane_res),
		.out_valid  (out_valid),
		.wb         (wb),
		.ovf_mask   (ovf_mask),
		.ill_mask   (ill_mask),
		.trap_count (trap_count)
	);

endmodule

`default_nettype wire

// ==== tests/alu_cluster_props.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module alu_cluster_props import alu_pkg::*; (
	input wire             clk,
	input wire             arst_n,
	input wire             in_valid,
	input wire             out_valid,
	input wire wb_slot_t   wb [`ALU_LANES],
	input wire lane_mask_t ovf_mask,
	input wire lane_mask_t ill_mask,
	input wire trap_cnt_t  trap_count
);

	lane_mask_t we_bits;

	always_comb begin
		for (int i = 0; i < `ALU_LANES; i++) begin
			we_bits[i] = wb[i].we;
		end
	end

	// three register stages between issue and write-back
	a_out_latency: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid == $past(in_valid, 3))
		else $error("out_valid does not follow in_valid by 3 cycles");

	a_we_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
		!out_valid |-> we_bits == '0)
		else $error("write enable high without out_valid");

	a_we_suppressed: assert property (@(posedge clk) disable iff (!arst_n)
		(we_bits & (ovf_mask | ill_mask)) == '0)
		else $error("write enable high on an overflowing or illegal lane");

	a_trap_monotonic: assert property (@(posedge clk) disable iff (!arst_n)
		trap_count >= $past(trap_count))
		else $error("trap_count decreased");

endmodule

bind alu_cluster alu_cluster_props u_props (
	.clk        (clk),
	.arst_n     (arst_n),
	.in_valid   (in_valid),
	.out_valid  (out_valid),
	.wb         (wb),
	.ovf_mask   (ovf_mask),
	.ill_mask   (ill_mask),
	.trap_count (trap_count)
);

`default_nettype wire

// ==== tests/alu_cluster_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module alu_cluster_tb import alu_pkg::*; ();

	localparam int HALF_PERIOD = 4; // 8 ns clock
	localparam int LANES       = `ALU_LANES;

	// slot inputs plus expected write-back for one stimulus line
	typedef struct packed {
		issue_slot_t slot;
		word_t       value;
		logic        we;
		reg_idx_t    dest;
		logic        ovf;
		logic        ill;
	} vec_t;

	typedef struct packed {
		int bundle;
		int cycle; // cycle count at the strobe
	} pend_t;

	logic        clk;
	logic        arst_n;
	logic        in_valid;
	issue_slot_t slots [LANES];
	logic        out_valid;
	wb_slot_t    wb [LANES];
	lane_mask_t  ovf_mask;
	lane_mask_t  ill_mask;
	trap_cnt_t   trap_count;

	vec_t  vecs [$];
	pend_t pending [$]; // bundles in flight in issue order
	int    n_bundles = 0;
	int    cycle_cnt = 0;
	int    exp_traps = 0; // running sum of expected overflow bits
	int    errors    = 0;
	int    n_checks  = 0;
	int    tests_run = 0;
	int    tests_bad = 0;
	logic  loaded    = 1'b0;

	alu_cluster u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.slots      (slots),
		.out_valid  (out_valid),
		.wb         (wb),
		.ovf_mask   (ovf_mask),
		.ill_mask   (ill_mask),
		.trap_count (trap_count)
	);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [9];
		vec_t        v;

		fd = $fopen("tests/alu_cluster_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file tests/alu_cluster_stimulus.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
				if (n == 9) begin
					if (f[0] != 32'(vecs.size() % LANES)) begin
						$display("stimulus slot index %0h is out of order", f[0]);
						errors++;
					end
					v.slot.instr  = f[1];
					v.slot.rs_val = f[2];
					v.slot.rt_val = f[3];
					v.value       = f[4];
					v.we          = f[5][0];
					v.dest        = f[6][4:0];
					v.ovf         = f[7][0];
					v.ill         = f[8][0];
					vecs.push_back(v);
				end else if (n > 0) begin
					$display("stimulus line could not be parsed: %s", line);
					errors++;
				end
			end
		end
		$fclose(fd);
		n_bundles = vecs.size() / LANES;
		if (vecs.size() % LANES != 0) begin
			$display("stimulus file ends in a partial bundle");
			errors++;
		end
		if (n_bundles == 0) begin
			$display("stimulus file holds no bundles");
			errors++;
		end
	endtask

	task automatic check_hex(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		n_checks++;
		assert (got === exp) else begin
			$display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
			errors++;
		end
	endtask

	task automatic drive_bundle(input int b);
		pend_t p;

		@(posedge clk);
		#1;
		for (int i = 0; i < LANES; i++) begin
			slots[i] = vecs[b*LANES + i].slot;
		end
		in_valid = 1'b1;
		p.bundle = b;
		p.cycle  = cycle_cnt;
		pending.push_back(p);
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (pending.size() != 0) @(negedge clk);
		repeat (2) @(negedge clk); // room for a stray out_valid to show up
	endtask

	task automatic compare_bundle(input int b);
		vec_t       e;
		lane_mask_t exp_ovf;
		lane_mask_t exp_ill;

		exp_ovf = '0;
		exp_ill = '0;
		for (int i = 0; i < LANES; i++) begin
			e          = vecs[b*LANES + i];
			exp_ovf[i] = e.ovf;
			exp_ill[i] = e.ill;
			if (e.ovf) begin
				exp_traps++;
			end
			check_hex($sformatf("wb[%0d].we", i), 32'(e.we), 32'(wb[i].we));
			if (!e.ill) begin // dest and value undefined for illegal slots
				check_hex($sformatf("wb[%0d].dest", i), 32'(e.dest), 32'(wb[i].dest));
				check_hex($sformatf("wb[%0d].value", i), e.value, wb[i].value);
			end
		end
		check_hex("ovf_mask", 32'(exp_ovf), 32'(ovf_mask));
		check_hex("ill_mask", 32'(exp_ill), 32'(ill_mask));
		check_hex("trap_count", 32'(exp_traps), 32'(trap_count));
	endtask

	task automatic check_outputs();
		pend_t p;
		int    age;

		if (out_valid) begin
			assert (pending.size() != 0) else begin
				$display("out_valid went high with no bundle in flight");
				errors++;
			end
			if (pending.size() != 0) begin
				p   = pending.pop_front();
				age = cycle_cnt - p.cycle;
				assert (age == 3) else begin
					$display("bundle %0d came out %0d cycles after its strobe, not 3",
						p.bundle, age);
					errors++;
				end
				compare_bundle(p.bundle);
			end
		end else if (pending.size() != 0) begin
			age = cycle_cnt - pending[0].cycle;
			assert (age < 3) else begin
				$display("out_valid missing for bundle %0d, %0d cycles after its strobe",
					pending[0].bundle, age);
				errors++;
			end
			if (age >= 3) begin
				p = pending.pop_front();
			end
		end
	endtask

	// outputs settle after the rising edge so they are sampled on the falling one
	always @(negedge clk) begin
		if (arst_n) begin
			check_outputs();
		end
	end

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_bad++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
		end
	endtask

	initial begin
		int limit;

		wait (loaded);
		limit = 2 * n_bundles * 2 + 20; // two passes over the bundles
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d clock cycles with %0d bundles in flight",
			limit, pending.size());
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		int errs_before;

		arst_n   = 1'b0;
		in_valid = 1'b0;
		for (int i = 0; i < LANES; i++) begin
			slots[i] = '0;
		end
		load_vectors();
		loaded = 1'b1;

		// reset values are checked while arst_n is still low
		errs_before = errors;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_hex("out_valid", 32'h0, 32'(out_valid));
		check_hex("ovf_mask", 32'h0, 32'(ovf_mask));
		check_hex("ill_mask", 32'h0, 32'(ill_mask));
		check_hex("trap_count", 32'h0, 32'(trap_count));
		for (int i = 0; i < LANES; i++) begin
			check_hex($sformatf("wb[%0d].we", i), 32'h0, 32'(wb[i].we));
		end
		@(posedge clk);
		#1;
		arst_n = 1'b1; // released after 4 cycles
		finish_test("reset state", errs_before);

		errs_before = errors;
		for (int b = 0; b < n_bundles; b++) begin
			drive_bundle(b);
			drive_idle();
		end
		wait_drain();
		finish_test("single strobes", errs_before);

		errs_before = errors;
		for (int b = 0; b < n_bundles; b++) begin
			drive_bundle(b); // one bundle every cycle
		end
		drive_idle();
		wait_drain();
		finish_test("back to back", errs_before);

		$display("%0d tests run, %0d with errors, %0d checks, %0d errors",
			tests_run, tests_bad, n_checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/alu_cluster_stimulus.txt ====
# columns, all hex: slot instr rs_val rt_val exp_value exp_we exp_dest exp_ovf exp_ill
# four lines per bundle; value and dest are don't-care on illegal slots
# bundle 0, add and sub overflow against addu and subu
0 00221820 7fffffff 00000001 80000000 0 03 1 0
1 00222021 7fffffff 00000001 80000000 1 04 0 0
2 00222822 80000000 00000001 7fffffff 0 05 1 0
3 00223023 80000000 00000001 7fffffff 1 06 0 0
# bundle 1, addi overflow both ways, addiu, add without overflow
0 20270001 7fffffff 00000000 80000000 0 07 1 0
1 2028ffff 80000000 00000000 7fffffff 0 08 1 0
2 2429ffff 00000010 00000000 0000000f 1 09 0 0
3 00225020 00000005 fffffffd 00000002 1 0a 0 0
# bundle 2, and or xor nor
0 00221824 f0f0ff00 0ff0f0f0 00f0f000 1 03 0 0
1 00222025 f0f0ff00 0ff0f0f0 fff0fff0 1 04 0 0
2 00222826 f0f0ff00 0ff0f0f0 ff000ff0 1 05 0 0
3 00223027 f0f0ff00 0ff0f0f0 000f000f 1 06 0 0
# bundle 3, andi ori xori zero-extend, slti sign-extends
0 30238f0f ffffffff 00000000 00008f0f 1 03 0 0
1 34248000 12340000 00000000 12348000 1 04 0 0
2 3825ffff ffff0000 00000000 ffffffff 1 05 0 0
3 2826fffe 00000005 00000000 00000000 1 06 0 0
# bundle 4, sll srl sra by shamt field, lui
0 00221900 0000001f 0000f00f 000f00f0 1 03 0 0
1 00222202 0000001f 80000000 00800000 1 04 0 0
2 00222a03 0000001f 80000000 ff800000 1 05 0 0
3 3c26beef 00000003 00000000 beef0000 1 06 0 0
# bundle 5, sllv srlv srav by rs[4:0]
0 00221804 00000024 0000000f 000000f0 1 03 0 0
1 00222006 00000010 f0000000 0000f000 1 04 0 0
2 00222807 0000001f 80000000 ffffffff 1 05 0 0
3 00223007 00000004 7ffffff0 07ffffff 1 06 0 0
# bundle 6, signed and unsigned compares with mixed signs
0 0022182a ffffffff 00000001 00000001 1 03 0 0
1 0022202b ffffffff 00000001 00000000 1 04 0 0
2 28250001 ffffffff 00000000 00000001 1 05 0 0
3 2c260001 ffffffff 00000000 00000000 1 06 0 0
# bundle 7, dest zero, unknown funct, unknown opcode
0 00220020 00000003 00000004 00000007 0 00 0 0
1 34200055 00000100 00000000 00000155 0 00 0 0
2 0022183f 00000003 00000004 00000000 0 03 0 1
3 8c230010 00000003 00000004 00000000 0 03 0 1

// ==== filelist.f ====
+incdir+design
design/alu_pkg.sv
design/alu_core.sv
design/exec_lane.sv
design/issue_decode.sv
design/retire_collect.sv
design/alu_cluster.sv
tests/alu_cluster_props.sv
tests/alu_cluster_tb.sv

// ==== Makefile ====
SRCS = $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: all run clean

all: obj_dir/Valu_cluster_tb

# rebuilt only when a source or the file list changes
obj_dir/Valu_cluster_tb: $(SRCS) filelist.f
	verilator --binary --timing --assert -Wno-fatal \
		--top-module alu_cluster_tb -Mdir obj_dir -f filelist.f

# the log decides pass or fail
run: obj_dir/Valu_cluster_tb
	./obj_dir/Valu_cluster_tb > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log
